// ==== sim.f ====
common/bridge_pkg.sv
logic/ahb_front.sv
logic/addr_decoder.sv
apb/apb_sequencer.sv
logic/ahb_apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_bridge.sv

// ==== Makefile ====
# Verilator build and run for the AHB-to-APB bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_bridge
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)

# Pass or fail is decided by the pass line in the log
check: run
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_bridge.sv ====
/*
 * Testbench for the AHB-to-APB bridge
 *   clock, reset and four APB slave models
 *   table of AHB transfers with expected hrdata and psel
 *   shadow copy of writes for read-back values
 *   idle-bus and post-reset checks
 */

`timescale 1ns/1ps

module tb_bridge;

  import bridge_pkg::*;

  localparam int NUM_ROWS = 15;
  localparam int TIMEOUT_CYCLES = 50;
  localparam htrans_t TRANS_IDLE = 2'b00;
  localparam htrans_t TRANS_BUSY = 2'b01;

  logic       hclk19;
  logic       hreset_n19;
  logic       hsel;
  addr_t      haddr;
  htrans_t    htrans;
  logic       hwrite;
  data_t      hwdata;
  data_t      hrdata;
  logic       hready;
  slave_sel_t pready;
  data_t      prdata [NUM_SLAVES];
  slave_sel_t psel;
  logic       penable;
  addr_t      paddr;
  logic       pwrite;
  data_t      pwdata;
  logic [3:0] wait_cycles;

  // Stimulus table
  string      row_name     [NUM_ROWS];
  logic       row_write    [NUM_ROWS];
  addr_t      row_addr     [NUM_ROWS];
  data_t      row_wdata    [NUM_ROWS];
  logic [3:0] row_wait     [NUM_ROWS];
  data_t      row_exp_data [NUM_ROWS];
  slave_sel_t row_exp_sel  [NUM_ROWS];
  int         row_count;

  data_t shadow [addr_t];
  data_t last_read;
  int    errors_in_test;
  int    tests_run;
  int    tests_failed;
  logic  timed_out;

  always #20 hclk19 = ~hclk19;

  ahb_apb_bridge i_ahb_apb_bridge (
    .hclk19     (hclk19),
    .hreset_n19 (hreset_n19),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hrdata     (hrdata),
    .hready     (hready),
    .pready     (pready),
    .prdata0    (prdata[0]),
    .prdata1    (prdata[1]),
    .prdata2    (prdata[2]),
    .prdata3    (prdata[3]),
    .psel       (psel),
    .penable    (penable),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .pwdata     (pwdata)
  );

  // One model per psel bit
  for (genvar g = 0; g < NUM_SLAVES; g++) begin : g_slave
    apb_slave_model i_apb_slave_model (
      .hclk19      (hclk19),
      .hreset_n19  (hreset_n19),
      .psel        (psel[g]),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .wait_cycles (wait_cycles),
      .pready      (pready[g]),
      .prdata      (prdata[g])
    );
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("Error %s: hrdata expected %h, actual %h", name, expected, actual);
      errors_in_test++;
    end
  endtask

  task automatic check_sel(input string name, input slave_sel_t expected,
                           input slave_sel_t actual);
    if (actual !== expected) begin
      $display("Error %s: psel expected %b, actual %b", name, expected, actual);
      errors_in_test++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("Error %s: paddr expected %h, actual %h", name, expected, actual);
      errors_in_test++;
    end
  endtask

  task automatic check_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error %s: hready low cycles expected %0d, actual %0d", name, expected, actual);
      errors_in_test++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors_in_test == 0) begin
      $display("PASS: %s", name);
    end else begin
      tests_failed++;
      $display("FAIL: %s", name);
    end
    errors_in_test = 0;
  endtask

  task automatic report_timeout(input string name);
    $display("Timeout in %s: hready stayed low for %0d cycles", name, TIMEOUT_CYCLES);
    errors_in_test++;
    timed_out = 1'b1;
  endtask

  // --------------------
  // Table construction
  // --------------------
  // Expected read data follows the shadow of earlier mapped writes
  task automatic add_row(input string name, input logic wr, input addr_t addr,
                         input logic [3:0] wait_n, input slave_sel_t exp_sel);
    data_t wdata;
    data_t exp_data;
    addr_t key;
    wdata = $urandom;
    key = {addr[ADDR_W-1:2], 2'b00};
    if (wr) begin
      // hrdata keeps the last read value across writes
      exp_data = last_read;
      if (exp_sel != '0) begin
        shadow[key] = wdata;
      end
    end else begin
      if (exp_sel == '0) begin
        exp_data = '0;
      end else if (shadow.exists(key)) begin
        exp_data = shadow[key];
      end else begin
        exp_data = '0;
      end
      last_read = exp_data;
    end
    row_name[row_count]     = name;
    row_write[row_count]    = wr;
    row_addr[row_count]     = addr;
    row_wdata[row_count]    = wdata;
    row_wait[row_count]     = wait_n;
    row_exp_data[row_count] = exp_data;
    row_exp_sel[row_count]  = exp_sel;
    row_count++;
  endtask

  task automatic build_table();
    add_row("wr_slave0", 1'b1, 32'h0000_0000, 4'd0, 4'b0001);
    add_row("rd_slave0", 1'b0, 32'h0000_0000, 4'd0, 4'b0001);
    add_row("wr_slave1", 1'b1, 32'h0000_1004, 4'd0, 4'b0010);
    add_row("rd_slave1", 1'b0, 32'h0000_1004, 4'd0, 4'b0010);
    add_row("wr_slave2", 1'b1, 32'h0000_2008, 4'd0, 4'b0100);
    add_row("rd_slave2", 1'b0, 32'h0000_2008, 4'd0, 4'b0100);
    add_row("wr_slave3", 1'b1, 32'h0000_400C, 4'd0, 4'b1000);
    add_row("rd_slave3", 1'b0, 32'h0000_400C, 4'd0, 4'b1000);
    add_row("wr_slave1_wait2", 1'b1, 32'h0000_1010, 4'd2, 4'b0010);
    add_row("rd_wait0", 1'b0, 32'h0000_1010, 4'd0, 4'b0010);
    add_row("rd_wait1", 1'b0, 32'h0000_1010, 4'd1, 4'b0010);
    add_row("rd_wait3", 1'b0, 32'h0000_2008, 4'd3, 4'b0100);
    // 0x3000 aliases slave 0 word 0 in bits 7:2
    add_row("wr_unmapped", 1'b1, 32'h0000_3000, 4'd0, 4'b0000);
    add_row("rd_unmapped", 1'b0, 32'h0000_3000, 4'd0, 4'b0000);
    add_row("rd_slave0_after", 1'b0, 32'h0000_0000, 4'd0, 4'b0001);
  endtask

  // --------------------
  // Bus activity
  // --------------------
  task automatic run_transfer(input int i);
    int         low_cycles;
    slave_sel_t psel_seen;
    addr_t      paddr_seen;
    logic       finished;
    low_cycles = 0;
    psel_seen = '0;
    paddr_seen = 'x;
    finished = 1'b0;
    @(posedge hclk19);
    hsel        <= 1'b1;
    haddr       <= row_addr[i];
    htrans      <= HTRANS_NONSEQ;
    hwrite      <= row_write[i];
    hwdata      <= row_wdata[i];
    wait_cycles <= row_wait[i];
    // Request dropped after the accept edge; hwdata held for the data phase
    @(posedge hclk19);
    hsel   <= 1'b0;
    htrans <= TRANS_IDLE;
    for (int n = 0; n < TIMEOUT_CYCLES && !finished; n++) begin
      @(negedge hclk19);
      if (hready) begin
        finished = 1'b1;
      end else begin
        low_cycles++;
        psel_seen = psel_seen | psel;
        if (penable) begin
          paddr_seen = paddr;
        end
      end
    end
    if (!finished) begin
      report_timeout(row_name[i]);
    end else begin
      check_sel(row_name[i], row_exp_sel[i], psel_seen);
      check_addr(row_name[i], row_addr[i], paddr_seen);
      check_data(row_name[i], row_exp_data[i], hrdata);
      check_cycles(row_name[i], 3 + int'(row_wait[i]), low_cycles);
    end
    end_test(row_name[i]);
  endtask

  // No transfer may start for these select/type pairs
  task automatic check_idle_bus(input string name, input logic sel, input htrans_t trans);
    int         low_cycles;
    slave_sel_t psel_seen;
    low_cycles = 0;
    psel_seen = '0;
    @(posedge hclk19);
    hsel   <= sel;
    htrans <= trans;
    haddr  <= 32'h0000_1000;
    hwrite <= 1'b0;
    for (int n = 0; n < 6; n++) begin
      @(negedge hclk19);
      if (!hready) begin
        low_cycles++;
      end
      psel_seen = psel_seen | psel;
    end
    @(posedge hclk19);
    hsel   <= 1'b0;
    htrans <= TRANS_IDLE;
    check_cycles(name, 0, low_cycles);
    check_sel(name, '0, psel_seen);
    end_test(name);
  endtask

  initial begin
    void'($urandom(9027));
    hclk19 = 1'b0;
    hreset_n19 = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = TRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    wait_cycles = '0;
    row_count = 0;
    last_read = '0;
    errors_in_test = 0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;

    repeat (4) @(posedge hclk19);
    hreset_n19 <= 1'b1;

    // Bus state straight out of reset
    @(negedge hclk19);
    if (!hready) begin
      $display("hready is not high after reset");
      errors_in_test++;
    end
    if (penable) begin
      $display("penable is not low after reset");
      errors_in_test++;
    end
    check_sel("after_reset", '0, psel);
    check_data("after_reset", '0, hrdata);
    end_test("after_reset");

    build_table();
    for (int i = 0; i < row_count && !timed_out; i++) begin
      run_transfer(i);
    end

    if (!timed_out) begin
      check_idle_bus("idle_hsel_low", 1'b0, HTRANS_NONSEQ);
      check_idle_bus("idle_htrans_idle", 1'b1, TRANS_IDLE);
      check_idle_bus("idle_htrans_busy", 1'b1, TRANS_BUSY);
    end

    $display("Tests: %0d run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/apb_slave_model.sv ====
/*
 * Behavioral APB slave for the bridge testbench
 *   64 words of storage indexed by paddr[7:2]
 *   programmable pready wait count
 */

`timescale 1ns/1ps

module apb_slave_model (
  input  logic              hclk19,
  input  logic              hreset_n19,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  bridge_pkg::addr_t paddr,
  input  bridge_pkg::data_t pwdata,
  input  logic [3:0]        wait_cycles,
  output logic              pready,
  output bridge_pkg::data_t prdata
);

  import bridge_pkg::*;

  data_t      mem [64];
  logic [3:0] wait_cnt;
  logic       in_access;

  assign in_access = psel && penable;

  // Ready once the requested number of wait cycles has passed
  assign pready = (wait_cnt >= wait_cycles);

  assign prdata = psel ? mem[paddr[7:2]] : '0;

  // Wait counter, cleared outside access
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      wait_cnt <= '0;
    end else if (in_access && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  // Storage written at the completing access edge
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= '0;
      end
    end else if (in_access && pready && pwrite) begin
      mem[paddr[7:2]] <= pwdata;
    end
  end

endmodule

// ==== logic/ahb_apb_bridge.sv ====
/*
 * AHB-to-APB bridge top level
 *   AHB front end and address decoder in parallel
 *   APB sequencer combining both
 *   write data passed straight to the APB bus
 */

`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                   hclk19,
  input  logic                   hreset_n19,
  // AHB side
  input  logic                   hsel,
  input  bridge_pkg::addr_t      haddr,
  input  bridge_pkg::htrans_t    htrans,
  input  logic                   hwrite,
  input  bridge_pkg::data_t      hwdata,
  output bridge_pkg::data_t      hrdata,
  output logic                   hready,
  // APB side
  input  bridge_pkg::slave_sel_t pready,
  input  bridge_pkg::data_t      prdata0,
  input  bridge_pkg::data_t      prdata1,
  input  bridge_pkg::data_t      prdata2,
  input  bridge_pkg::data_t      prdata3,
  output bridge_pkg::slave_sel_t psel,
  output logic                   penable,
  output bridge_pkg::addr_t      paddr,
  output logic                   pwrite,
  output bridge_pkg::data_t      pwdata
);

  import bridge_pkg::*;

  logic       transfer_accept;
  logic       data_phase;
  addr_t      haddr_q;
  logic       hwrite_q;
  slave_sel_t slave_sel;
  logic       done;
  data_t      rdata_muxed;

  // Write data needs no staging, APB samples it during access
  assign pwdata = hwdata;

  // --------------------
  // AHB side
  // --------------------
  ahb_front i_ahb_front (
    .hclk19          (hclk19),
    .hreset_n19      (hreset_n19),
    .hsel            (hsel),
    .haddr           (haddr),
    .htrans          (htrans),
    .hwrite          (hwrite),
    .done            (done),
    .rdata_muxed     (rdata_muxed),
    .transfer_accept (transfer_accept),
    .data_phase      (data_phase),
    .haddr_q         (haddr_q),
    .hwrite_q        (hwrite_q),
    .hready          (hready),
    .hrdata          (hrdata)
  );

  // Samples the same accepted address as the front end
  addr_decoder i_addr_decoder (
    .hclk19          (hclk19),
    .hreset_n19      (hreset_n19),
    .transfer_accept (transfer_accept),
    .haddr           (haddr),
    .slave_sel       (slave_sel)
  );

  // --------------------
  // APB side
  // --------------------
  apb_sequencer i_apb_sequencer (
    .hclk19      (hclk19),
    .hreset_n19  (hreset_n19),
    .data_phase  (data_phase),
    .haddr_q     (haddr_q),
    .hwrite_q    (hwrite_q),
    .slave_sel   (slave_sel),
    .pready      (pready),
    .prdata0     (prdata0),
    .prdata1     (prdata1),
    .prdata2     (prdata2),
    .prdata3     (prdata3),
    .psel        (psel),
    .penable     (penable),
    .paddr       (paddr),
    .pwrite      (pwrite),
    .done        (done),
    .rdata_muxed (rdata_muxed)
  );

endmodule

// ==== apb/apb_sequencer.sv ====
/*
 * APB master sequencer
 *   idle / setup / access state machine
 *   psel, penable, paddr and pwrite generation
 *   pready qualification and read data mux
 *   completion pulse back to the AHB side
 */

`timescale 1ns/1ps

module apb_sequencer (
  input  logic                   hclk19,
  input  logic                   hreset_n19,
  input  logic                   data_phase,
  input  bridge_pkg::addr_t      haddr_q,
  input  logic                   hwrite_q,
  input  bridge_pkg::slave_sel_t slave_sel,
  input  bridge_pkg::slave_sel_t pready,
  input  bridge_pkg::data_t      prdata0,
  input  bridge_pkg::data_t      prdata1,
  input  bridge_pkg::data_t      prdata2,
  input  bridge_pkg::data_t      prdata3,
  output bridge_pkg::slave_sel_t psel,
  output logic                   penable,
  output bridge_pkg::addr_t      paddr,
  output logic                   pwrite,
  output logic                   done,
  output bridge_pkg::data_t      rdata_muxed
);

  import bridge_pkg::*;

  apb_state_t state;
  logic       sel_ready;
  data_t      prdata_arr [NUM_SLAVES];

  // --------------------
  // Return path
  // --------------------
  assign prdata_arr[0] = prdata0;
  assign prdata_arr[1] = prdata1;
  assign prdata_arr[2] = prdata2;
  assign prdata_arr[3] = prdata3;

  // Unmapped address leaves psel empty, treated as ready
  assign sel_ready = (psel == '0) || |(psel & pready);

  // Selected slave's data only; zero when nothing is selected
  always_comb begin
    rdata_muxed = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      rdata_muxed = rdata_muxed | (prdata_arr[i] & {DATA_W{psel[i]}});
    end
  end

  // Single-cycle completion strobe to the AHB front end
  assign done = (state == access) && sel_ready;

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      state   <= idle;
      psel    <= '0;
      penable <= 1'b0;
      paddr   <= '0;
      pwrite  <= 1'b0;
    end else begin
      unique case (state)
        idle: begin
          if (data_phase) begin
            state  <= setup;
            psel   <= slave_sel;
            paddr  <= haddr_q;
            pwrite <= hwrite_q;
          end
        end

        setup: begin
          state   <= access;
          penable <= 1'b1;
        end

        access: begin
          // Hold everything while the slave stretches the access
          if (sel_ready) begin
            state   <= idle;
            penable <= 1'b0;
            psel    <= '0;
          end
        end

        default: begin
          state   <= idle;
          penable <= 1'b0;
          psel    <= '0;
        end
      endcase
    end
  end

endmodule

// ==== logic/addr_decoder.sv ====
/*
 * Registered APB slave address decoder
 *   range compare against the package map
 *   selection captured on the AHB accept edge
 */

`timescale 1ns/1ps

module addr_decoder (
  input  logic                   hclk19,
  input  logic                   hreset_n19,
  input  logic                   transfer_accept,
  input  bridge_pkg::addr_t      haddr,
  output bridge_pkg::slave_sel_t slave_sel
);

  import bridge_pkg::*;

  slave_sel_t range_hit;

  // --------------------
  // Range compare
  // --------------------
  // One-hot for a mapped address, all zero in the gap
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      range_hit[i] = (haddr >= SLAVE_START[i]) && (haddr <= SLAVE_END[i]);
    end
  end

  // Held until the next accepted transfer
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      slave_sel <= '0;
    end else if (transfer_accept) begin
      slave_sel <= range_hit;
    end
  end

endmodule

// ==== logic/ahb_front.sv ====
/*
 * AHB slave front end
 *   transfer qualification and accept pulse
 *   address and direction capture
 *   hready and hrdata generation
 */

`timescale 1ns/1ps

module ahb_front (
  input  logic                hclk19,
  input  logic                hreset_n19,
  input  logic                hsel,
  input  bridge_pkg::addr_t   haddr,
  input  bridge_pkg::htrans_t htrans,
  input  logic                hwrite,
  input  logic                done,
  input  bridge_pkg::data_t   rdata_muxed,
  output logic                transfer_accept,
  output logic                data_phase,
  output bridge_pkg::addr_t   haddr_q,
  output logic                hwrite_q,
  output logic                hready,
  output bridge_pkg::data_t   hrdata
);

  import bridge_pkg::*;

  logic valid_trans;

  // Only NONSEQ and SEQ move data; IDLE and BUSY are ignored
  assign valid_trans = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Accept only while no transfer is outstanding
  assign transfer_accept = hready && valid_trans;

  // --------------------
  // Phase tracking
  // --------------------
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      hready     <= 1'b1;
      data_phase <= 1'b0;
    end else if (transfer_accept) begin
      hready     <= 1'b0;
      data_phase <= 1'b1;
    end else if (done) begin
      // APB side finished, release the AHB bus
      hready     <= 1'b1;
      data_phase <= 1'b0;
    end
  end

  // Address phase capture
  always_ff @(posedge hclk19) begin
    if (transfer_accept) begin
      haddr_q  <= haddr;
      hwrite_q <= hwrite;
    end
  end

  // --------------------
  // Read data return
  // --------------------
  always_ff @(posedge hclk19 or negedge hreset_n19) begin
    if (!hreset_n19) begin
      hrdata <= '0;
    end else if (done && !hwrite_q) begin
      hrdata <= rdata_muxed;
    end
  end

endmodule

// ==== common/bridge_pkg.sv ====
/*
 * Shared definitions for the AHB-to-APB bridge
 *   bus widths and vector types
 *   slave count and the APB address map
 *   AHB transfer type codes
 *   APB sequencer state encoding
 */

package bridge_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int HTRANS_W = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [HTRANS_W-1:0] htrans_t;

  // --------------------
  // Slave address map
  // --------------------
  localparam int NUM_SLAVES = 4;

  // One bit per APB slave
  typedef logic [NUM_SLAVES-1:0] slave_sel_t;

  // Inclusive ranges; 0x3000..0x3FFF left unmapped
  localparam addr_t SLAVE_START [NUM_SLAVES] = '{
    32'h0000_0000,
    32'h0000_1000,
    32'h0000_2000,
    32'h0000_4000
  };

  localparam addr_t SLAVE_END [NUM_SLAVES] = '{
    32'h0000_0FFF,
    32'h0000_1FFF,
    32'h0000_2FFF,
    32'h0000_4FFF
  };

  // AHB transfer types the bridge responds to
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ = 2'b11;

  // APB sequencer states
  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } apb_state_t;

endpackage
